// File: bench/tb_uart_echo.sv
// testbench for the UART line echo
// serial driver, serial monitor on the echo, line model, tests, watchdog
`timescale 1ns/10ps

module tb_uart_echo import uart_pkg::*; ();

    localparam int MAX_FRAMES = 800;  // worst case frames sent and echoed over all tests
    localparam int WATCHDOG_CYCLES = MAX_FRAMES * 10 * CLKS_PER_BIT * 6 / 5;

    logic       sys_clk;
    logic       sys_rst_n;
    logic       uart_rx_port;
    logic       uart_tx_port;
    logic [7:0] uart_rx_data;

    logic [7:0] line_q[$];   // line to send next
    logic [7:0] exp_q[$];    // model output
    logic [7:0] got_q[$];    // decoded echo
    logic [7:0] last_rx;     // expected uart_rx_data
    logic [7:0] mon_byte;
    int         stored_n;        // model fill level of the current line
    int         credits_seen;    // credit pulses counted so far
    int         credits_target;  // credit pulses awaited
    int         err_cnt;         // echo errors
    int         rx_errs;         // uart_rx_data errors
    int         rx_checks;
    int         pass_cnt;
    int         fail_cnt;
    int         errs_at_start;   // err_cnt when the current test began

    uart_echo_top u_dut (
        .sys_clk      (sys_clk),
        .sys_rst_n    (sys_rst_n),
        .uart_rx_port (uart_rx_port),
        .uart_tx_port (uart_tx_port),
        .uart_rx_data (uart_rx_data)
    );

    always #50 sys_clk = ~sys_clk;  // 100 ns period

    // sends one frame and checks uart_rx_data half a bit after its stop
    task send_byte(input logic [7:0] b, input logic bad_stop);
        logic [9:0] frame;
        frame = {~bad_stop, b, 1'b0};  // stop, data lsb first, start
        for (int i = 0; i < 10; i++) begin
            @(posedge sys_clk);
            uart_rx_port <= frame[i];
            repeat (CLKS_PER_BIT - 1) @(posedge sys_clk);
        end
        @(posedge sys_clk);
        uart_rx_port <= 1'b1;  // back to idle
        repeat (HALF_BIT) @(posedge sys_clk);
        @(negedge sys_clk);
        if (!bad_stop) last_rx = b;  // framing errors leave it alone
        rx_checks++;
        assert (uart_rx_data == last_rx) else begin
            $display("Mismatch uart_rx_data exp %h got %h", last_rx, uart_rx_data);
            rx_errs++;
        end
    endtask

    // keeps 15 data bytes at most and always the LF
    task model_byte(input logic [7:0] b, input bit keep);
        if (keep && (b == LINE_END || stored_n < STR_MAX_BYTES - 1)) begin
            exp_q.push_back(b);
            stored_n++;
        end
        if (b == LINE_END) stored_n = 0;
    endtask

    task send_line(input bit keep);
        foreach (line_q[i]) begin
            send_byte(line_q[i], 1'b0);
            model_byte(line_q[i], keep);
        end
        line_q.delete();
    endtask

    function automatic logic [7:0] rand_byte();
        logic [7:0] b;
        do begin
            b = 8'($urandom_range(255, 0));
        end while (b == LINE_END);
        return b;
    endfunction

    task fill_line(input int n);  // appends n random bytes without LF
        repeat (n) line_q.push_back(rand_byte());
    endtask

    task wait_echo(input int lines);  // credit pulse marks each echo end
        credits_target += lines;
        wait (credits_seen >= credits_target);
    endtask

    task check_echo;
        logic [7:0] e;
        logic [7:0] g;
        assert (got_q.size() == exp_q.size()) else begin
            $display("echo length wrong: expected %0d bytes, got %0d", exp_q.size(), got_q.size());
            err_cnt++;
        end
        while (got_q.size() > 0 && exp_q.size() > 0) begin
            e = exp_q.pop_front();
            g = got_q.pop_front();
            assert (g == e) else begin
                $display("Mismatch uart_tx_port byte exp %h got %h", e, g);
                err_cnt++;
            end
        end
        got_q.delete();
        exp_q.delete();
    endtask

    task report_test(input string name, input int errs);
        if (errs == 0) pass_cnt++;
        else fail_cnt++;
        $display("%s: %s (%0d errors)", name, (errs == 0) ? "ok" : "FAIL", errs);
        errs_at_start = err_cnt;
    endtask

    // decodes the echo at mid-bit on falling edges
    initial begin
        forever begin
            @(negedge sys_clk);
            if (sys_rst_n && uart_tx_port == 1'b0) begin
                repeat (HALF_BIT) @(negedge sys_clk);  // middle of start bit
                for (int i = 0; i < 8; i++) begin
                    repeat (CLKS_PER_BIT) @(negedge sys_clk);
                    mon_byte[i] = uart_tx_port;
                end
                repeat (CLKS_PER_BIT) @(negedge sys_clk);
                assert (uart_tx_port) else begin
                    $display("echo frame has a low stop bit");
                    err_cnt++;
                end
                got_q.push_back(mon_byte);
            end
        end
    end

    always @(negedge sys_clk) begin
        if (sys_rst_n && u_dut.line_bus.credit) credits_seen++;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge sys_clk);
        $display("timeout: echo did not complete");
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        void'($urandom(32'h31853002));
        sys_clk = 1'b0;
        sys_rst_n = 1'b0;
        uart_rx_port = 1'b1;
        last_rx = 8'h00;  // register clears on reset
        repeat (4) @(posedge sys_clk);
        sys_rst_n <= 1'b1;
        repeat (10) @(posedge sys_clk);

        for (int n = 0; n < 20; n++) begin  // random lines sent one at a time
            fill_line($urandom_range(13, 1));
            line_q.push_back(8'h0D);
            line_q.push_back(LINE_END);
            send_line(1'b1);
            wait_echo(1);
            check_echo();
        end
        report_test("random lines with CR LF", err_cnt - errs_at_start);

        fill_line(20);  // overlong line cut to 15 plus LF
        line_q.push_back(LINE_END);
        send_line(1'b1);
        wait_echo(1);
        check_echo();
        report_test("overlong line", err_cnt - errs_at_start);

        fill_line(14);  // 15 byte line with a 2 byte line right behind
        line_q.push_back(LINE_END);
        line_q.push_back(rand_byte());
        line_q.push_back(LINE_END);
        send_line(1'b1);
        wait_echo(2);
        check_echo();
        report_test("back to back lines", err_cnt - errs_at_start);

        fill_line(15);  // full line keeps the transmitter busy
        line_q.push_back(LINE_END);
        line_q.push_back(8'h41);
        line_q.push_back(LINE_END);
        send_line(1'b1);
        line_q.push_back(8'h42);  // arrives while "A" waits for the credit
        line_q.push_back(LINE_END);
        send_line(1'b0);
        wait_echo(2);
        repeat (3 * 10 * CLKS_PER_BIT) @(posedge sys_clk);  // idle with nothing more expected
        check_echo();
        fill_line(3);
        line_q.push_back(LINE_END);
        send_line(1'b1);
        wait_echo(1);
        check_echo();
        report_test("line dropped under back-pressure", err_cnt - errs_at_start);

        line_q.push_back(rand_byte());
        send_line(1'b1);
        send_byte(~last_rx, 1'b1);  // bad frame differs from the shown byte
        line_q.push_back(rand_byte());
        line_q.push_back(LINE_END);
        send_line(1'b1);
        wait_echo(1);
        check_echo();
        report_test("framing error byte", err_cnt - errs_at_start);

        $display("uart_rx_data after %0d frames: %s (%0d errors)", rx_checks,
                 (rx_errs == 0) ? "ok" : "FAIL", rx_errs);
        if (rx_errs == 0) pass_cnt++;
        else fail_cnt++;

        $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: files.f
hdl/uart_pkg.sv
hdl/uart_line_if.sv
hdl/uart_rx_byte.sv
hdl/uart_tx_byte.sv
hdl/uart_line_rx.sv
hdl/uart_line_tx.sv
hdl/uart_echo_top.sv
bench/tb_uart_echo.sv

// File: hdl/uart_echo_top.sv
// UART line echo top level
// byte receiver, line assembler, line transmitter, byte transmitter
// last framed byte shown on uart_rx_data
`timescale 1ns/10ps

module uart_echo_top (
    input  logic       sys_clk,
    input  logic       sys_rst_n,
    input  logic       uart_rx_port,
    output logic       uart_tx_port,
    output logic [7:0] uart_rx_data
);

    logic [7:0] rx_byte;
    logic       rx_valid;
    logic [7:0] tx_byte;
    logic       tx_start;
    logic       tx_ready;

    uart_line_if line_bus ();  // line plus credit return

    uart_rx_byte u_rx_byte (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .rx_pin    (uart_rx_port),
        .rx_byte   (rx_byte),
        .rx_valid  (rx_valid)
    );

    uart_line_rx u_line_rx (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .rx_byte   (rx_byte),
        .rx_valid  (rx_valid),
        .line_bus  (line_bus.src)
    );

    uart_line_tx u_line_tx (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .line_bus  (line_bus.dst),
        .tx_byte   (tx_byte),
        .tx_start  (tx_start),
        .tx_ready  (tx_ready)
    );

    uart_tx_byte u_tx_byte (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .tx_byte   (tx_byte),
        .tx_start  (tx_start),
        .tx_ready  (tx_ready),
        .tx_pin    (uart_tx_port)
    );

    always_ff @(posedge sys_clk) begin
        if (!sys_rst_n) begin
            uart_rx_data <= 8'd0;
        end else if (rx_valid) begin
            uart_rx_data <= rx_byte;  // framing errors never pulse rx_valid
        end
    end

endmodule

// File: hdl/uart_line_if.sv
// finished line hand-over between line assembler and line transmitter
// valid pulses once per line, credit pulses once per freed buffer
`timescale 1ns/10ps

interface uart_line_if import uart_pkg::*; ();

    line_t                line;    // line bytes, byte 0 first
    logic [STR_LEN_W-1:0] length;  // byte count incl LF
    logic                 valid;   // one cycle, costs one credit
    logic                 credit;  // one cycle, buffer freed

    // assembler side
    modport src (
        output line,
        output length,
        output valid,
        input  credit
    );

    // transmitter side
    modport dst (
        input  line,
        input  length,
        input  valid,
        output credit
    );

endinterface

// File: hdl/uart_line_rx.sv
// line assembler
// collects bytes up to LF, keeps 15 data bytes max plus LF
// holds the finished line until a credit is free
`timescale 1ns/10ps

module uart_line_rx import uart_pkg::*; (
    input  logic       sys_clk,
    input  logic       sys_rst_n,
    input  logic [7:0] rx_byte,
    input  logic       rx_valid,
    uart_line_if.src   line_bus
);

    line_t                line_buf;
    logic [STR_LEN_W-1:0] wr_cnt;      // bytes stored so far
    logic                 line_done;   // LF stored, waiting for hand-over
    logic [CRD_CNT_W-1:0] credit_cnt;
    logic                 is_end;
    logic                 has_room;
    logic                 store;
    logic                 take;        // hand-over this cycle

    assign is_end   = rx_byte == LINE_END;
    assign has_room = wr_cnt < STR_LEN_W'(STR_MAX_BYTES - 1);  // last slot kept for LF
    assign store    = rx_valid && !line_done && (is_end || has_room);
    assign take     = line_done && (credit_cnt != '0);

    assign line_bus.line   = line_buf;
    assign line_bus.length = wr_cnt;
    assign line_bus.valid  = take;

    always_ff @(posedge sys_clk) begin
        if (!sys_rst_n) begin
            wr_cnt     <= '0;
            line_done  <= 1'b0;
            credit_cnt <= CRD_CNT_W'(STR_CREDITS);
        end else begin
            if (take) begin
                line_done <= 1'b0;  // buffer free for next line
                wr_cnt    <= '0;
            end else if (store) begin
                wr_cnt <= wr_cnt + 1'b1;
                if (is_end) line_done <= 1'b1;
            end

            if (line_bus.credit && !take) begin
                credit_cnt <= credit_cnt + 1'b1;
            end else if (take && !line_bus.credit) begin
                credit_cnt <= credit_cnt - 1'b1;
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (store) line_buf[wr_cnt] <= rx_byte;
    end

    // a returned credit must belong to a line handed over earlier
    a_credit_bound: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        line_bus.credit |-> credit_cnt < CRD_CNT_W'(STR_CREDITS));

endmodule

// File: hdl/uart_line_tx.sv
// line transmitter
// single line buffer, feeds the byte transmitter in order
// returns the credit once the last stop bit is out
`timescale 1ns/10ps

module uart_line_tx import uart_pkg::*; (
    input  logic       sys_clk,
    input  logic       sys_rst_n,
    uart_line_if.dst   line_bus,
    output logic [7:0] tx_byte,
    output logic       tx_start,
    input  logic       tx_ready
);

    line_t                tx_buf;
    logic [STR_LEN_W-1:0] tx_len;
    logic [STR_LEN_W-1:0] rd_idx;      // next byte to send
    logic                 buf_full;
    logic                 bytes_left;

    assign bytes_left = rd_idx != tx_len;

    // index only reaches 16 once every byte is out, top bit not needed
    assign tx_byte  = tx_buf[rd_idx[STR_LEN_W-2:0]];
    assign tx_start = buf_full && tx_ready && bytes_left;

    // ready again with nothing left means the last frame has finished
    assign line_bus.credit = buf_full && tx_ready && !bytes_left;

    always_ff @(posedge sys_clk) begin
        if (!sys_rst_n) begin
            buf_full <= 1'b0;
            rd_idx   <= '0;
        end else if (line_bus.valid) begin
            buf_full <= 1'b1;
            rd_idx   <= '0;
        end else if (line_bus.credit) begin
            buf_full <= 1'b0;  // buffer released
        end else if (tx_start) begin
            rd_idx <= rd_idx + 1'b1;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (line_bus.valid) begin
            tx_buf <= line_bus.line;
            tx_len <= line_bus.length;
        end
    end

    // the credit scheme keeps the assembler away while a line is in flight
    a_no_overwrite: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        line_bus.valid |-> !buf_full);

endmodule

// File: hdl/uart_pkg.sv
// shared constants for the UART line echo
// bit timing, line capacity, credit count and the line type
package uart_pkg;

    localparam int CLK_FREQ_HZ  = 10_000_000;  // sys_clk rate
    localparam int BAUD_RATE    = 115_200;     // serial rate
    localparam int CLKS_PER_BIT = (CLK_FREQ_HZ + BAUD_RATE / 2) / BAUD_RATE; // rounds to 87
    localparam int HALF_BIT     = CLKS_PER_BIT / 2;      // start bit mid point
    localparam int CLK_CNT_W    = $clog2(CLKS_PER_BIT);  // clocks within one bit

    localparam int STR_MAX_BYTES = 16;                        // line capacity incl LF
    localparam int STR_LEN_W     = $clog2(STR_MAX_BYTES) + 1; // holds 0..16
    localparam logic [7:0] LINE_END = 8'h0A;                  // line feed

    // one buffer downstream, so one credit
    localparam int STR_CREDITS = 1;
    localparam int CRD_CNT_W   = $clog2(STR_CREDITS + 1);     // holds 0..STR_CREDITS

    // byte 0 goes out first
    typedef logic [STR_MAX_BYTES-1:0][7:0] line_t;

endpackage

// File: hdl/uart_rx_byte.sv
// 8N1 serial receiver
// two-flop sync, start edge detect, mid-bit sampling, stop bit check
`timescale 1ns/10ps

module uart_rx_byte import uart_pkg::*; (
    input  logic       sys_clk,
    input  logic       sys_rst_n,
    input  logic       rx_pin,
    output logic [7:0] rx_byte,
    output logic       rx_valid
);

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    rx_state_t            state;
    logic                 rx_meta;   // first sync stage
    logic                 rx_sync;   // usable line level
    logic                 rx_prev;   // for edge detect
    logic [CLK_CNT_W-1:0] clk_cnt;
    logic [2:0]           bit_cnt;   // data bit index
    logic [7:0]           shift;
    logic                 fall;
    logic                 bit_end;

    assign fall    = rx_prev & ~rx_sync;                           // high to low
    assign bit_end = clk_cnt == CLK_CNT_W'(CLKS_PER_BIT - 1);

    always_ff @(posedge sys_clk) begin
        if (!sys_rst_n) begin
            rx_meta <= 1'b1;  // idle line is high
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx_pin;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (!sys_rst_n) begin
            state    <= RX_IDLE;
            clk_cnt  <= '0;
            bit_cnt  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;  // single cycle pulse
            case (state)
                RX_IDLE: begin
                    clk_cnt <= '0;
                    bit_cnt <= '0;
                    if (fall) state <= RX_START;
                end
                RX_START: begin
                    if (clk_cnt == CLK_CNT_W'(HALF_BIT - 1)) begin
                        clk_cnt <= '0;
                        state   <= rx_sync ? RX_IDLE : RX_DATA;  // high at mid-bit is a glitch
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (bit_end) begin
                        clk_cnt <= '0;
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) state <= RX_STOP;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (bit_end) begin
                        clk_cnt  <= '0;
                        rx_valid <= rx_sync;  // low stop bit, frame dropped
                        state    <= RX_IDLE;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    always_ff @(posedge sys_clk) begin
        if (state == RX_DATA && bit_end) shift <= {rx_sync, shift[7:1]};  // lsb arrives first
        if (state == RX_STOP && bit_end && rx_sync) rx_byte <= shift;
    end

    // consumers count one byte per pulse
    a_rx_valid_pulse: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        rx_valid |=> !rx_valid);

endmodule

// File: hdl/uart_tx_byte.sv
// 8N1 serial transmitter
// one frame per tx_start, tx_ready high while idle
`timescale 1ns/10ps

module uart_tx_byte import uart_pkg::*; (
    input  logic       sys_clk,
    input  logic       sys_rst_n,
    input  logic [7:0] tx_byte,
    input  logic       tx_start,
    output logic       tx_ready,
    output logic       tx_pin
);

    logic                 busy;
    logic [CLK_CNT_W-1:0] clk_cnt;
    logic [3:0]           bit_cnt;  // 0 start, 1..8 data, 9 stop
    logic [8:0]           shift;    // data bits then stop
    logic                 bit_end;

    assign bit_end  = clk_cnt == CLK_CNT_W'(CLKS_PER_BIT - 1);
    assign tx_ready = ~busy;

    always_ff @(posedge sys_clk) begin
        if (!sys_rst_n) begin
            busy    <= 1'b0;
            clk_cnt <= '0;
            bit_cnt <= '0;
            tx_pin  <= 1'b1;  // line idles high
        end else if (!busy) begin
            clk_cnt <= '0;
            bit_cnt <= '0;
            if (tx_start) begin
                busy   <= 1'b1;
                tx_pin <= 1'b0;  // start bit
            end
        end else if (bit_end) begin
            clk_cnt <= '0;
            if (bit_cnt == 4'd9) begin
                busy <= 1'b0;  // stop bit done, pin already high
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
                tx_pin  <= shift[0];
            end
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (!busy && tx_start) begin
            shift <= {1'b1, tx_byte};
        end else if (busy && bit_end) begin
            shift <= {1'b1, shift[8:1]};  // lsb first, refill with stop level
        end
    end

    // the line transmitter must wait for ready
    a_tx_start_ready: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        tx_start |-> tx_ready);

endmodule
